/* Bender.yml */
package:
  name: cpc_bus

sources:
  - logic/cpc_pkg.sv
  - logic/cpc_bus_if.sv
  - logic/cpc_io_decode.sv
  - logic/cpc_gate_array.sv
  - logic/cpc_crtc_regs.sv
  - logic/cpc_ppi_port.sv
  - logic/cpc_mem_map.sv
  - logic/cpc_bus_top.sv
  - target: test
    files:
      - tests/cpc_bus_assert.sv
      - tests/tb_cpc_bus_top.sv

/* cpc_bus_top.f */
logic/cpc_pkg.sv
logic/cpc_bus_if.sv
logic/cpc_io_decode.sv
logic/cpc_gate_array.sv
logic/cpc_crtc_regs.sv
logic/cpc_ppi_port.sv
logic/cpc_mem_map.sv
logic/cpc_bus_top.sv
tests/cpc_bus_assert.sv
tests/tb_cpc_bus_top.sv

/* logic/cpc_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Decoded Z80 bus, from the port decoder to the register blocks
interface cpc_bus_if import cpc_pkg::*; ();

  // Byte on the CPU data pins
  byte_t      wr_data;

  // I/O write strobes, never more than one high
  logic       ga_wr;
  logic       rom_bank_wr;
  logic       ppi_a_wr;
  logic       ppi_c_wr;
  logic       ppi_ctrl_wr;
  logic       crtc_idx_wr;
  logic       crtc_data_wr;

  // Read and memory strobes
  logic       ppi_a_rd;
  logic       ppi_b_rd;
  logic       mem_rd;
  logic       mem_wr;

  // 16K region, top two address bits
  logic [1:0] region;

  modport decoder (
    output wr_data, ga_wr, rom_bank_wr, ppi_a_wr, ppi_c_wr, ppi_ctrl_wr,
    output crtc_idx_wr, crtc_data_wr, ppi_a_rd, ppi_b_rd, mem_rd, mem_wr, region
  );

  modport target (
    input  wr_data, ga_wr, rom_bank_wr, ppi_a_wr, ppi_c_wr, ppi_ctrl_wr,
    input  crtc_idx_wr, crtc_data_wr, ppi_a_rd, ppi_b_rd, mem_rd, mem_wr, region
  );

endinterface

`default_nettype wire

/* logic/cpc_bus_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_bus_top import cpc_pkg::*; #(
  parameter byte_t ROM_HI_BANK = 8'd7
) (
  input  wire logic        clk_cpu,
  input  wire logic        pwr_up_reset_n,
  // Z80 pins
  input  wire addr_t       i_address,
  input  wire byte_t       i_data,
  input  wire logic        i_n_rd,
  input  wire logic        i_n_wr,
  input  wire logic        i_n_mreq,
  input  wire logic        i_n_iorq,
  // External memories and peripherals
  input  wire byte_t       i_ram_data,
  input  wire byte_t       i_vram_data,
  input  wire byte_t       i_rom_data,
  input  wire byte_t       i_kbd_data,
  input  wire logic        i_long_vsync,
  input  wire pen_t        i_pen_index,
  output wire byte_t       o_data,
  output wire addr_t       o_rom_addr,
  output wire logic        o_ram_we,
  output wire logic        o_vram_we,
  // Video settings
  output wire logic [1:0]  o_mode,
  output wire colour_t     o_border_colour,
  output wire colour_t     o_pen_colour,
  output wire logic [2:0]  o_ram_bank,
  output wire logic [2:0]  o_ram_config,
  output wire byte_t       o_h_disp,
  output wire byte_t       o_v_disp,
  output wire scr_start_t  o_scr_start,
  // Keyboard and PSG
  output wire logic [3:0]  o_kbd_row,
  output wire logic        o_psg_bdir,
  output wire logic        o_psg_bc1,
  output wire byte_t       o_psg_data,
  output wire byte_t       o_ppi_control
);

  // ROM disables from the gate array
  wire logic  hi_rom_dis;
  wire logic  lo_rom_dis;
  // PPI read value into the data mux
  wire byte_t io_rd_data;
  wire logic  io_rd_valid;

  cpc_bus_if bus ();

  cpc_io_decode io_decode (
    .i_address, .i_data, .i_n_rd, .i_n_wr, .i_n_mreq, .i_n_iorq,
    .bus (bus.decoder)
  );

  cpc_gate_array gate_array (
    .clk_cpu, .pwr_up_reset_n, .bus (bus.target), .i_pen_index,
    .o_mode, .o_border_colour, .o_pen_colour,
    .o_hi_rom_dis (hi_rom_dis), .o_lo_rom_dis (lo_rom_dis),
    .o_ram_bank, .o_ram_config
  );

  cpc_crtc_regs crtc_regs (
    .clk_cpu, .pwr_up_reset_n, .bus (bus.target),
    .o_h_disp, .o_v_disp, .o_scr_start
  );

  cpc_ppi_port ppi_port (
    .clk_cpu, .pwr_up_reset_n, .bus (bus.target), .i_kbd_data, .i_long_vsync,
    .o_psg_data, .o_kbd_row, .o_psg_bdir, .o_psg_bc1, .o_ppi_control,
    .o_rd_data (io_rd_data), .o_rd_valid (io_rd_valid)
  );

  cpc_mem_map #(.ROM_HI_BANK (ROM_HI_BANK)) mem_map (
    .clk_cpu, .pwr_up_reset_n, .bus (bus.target), .i_address,
    .i_hi_rom_dis (hi_rom_dis), .i_lo_rom_dis (lo_rom_dis),
    .i_ram_data, .i_vram_data, .i_rom_data,
    .i_io_rd_data (io_rd_data), .i_io_rd_valid (io_rd_valid),
    .o_data, .o_rom_addr, .o_ram_we, .o_vram_we
  );

endmodule

`default_nettype wire

/* logic/cpc_crtc_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_crtc_regs import cpc_pkg::*; (
  input  wire logic   clk_cpu,
  input  wire logic   pwr_up_reset_n,
  cpc_bus_if.target   bus,
  output byte_t       o_h_disp,
  output byte_t       o_v_disp,
  output scr_start_t  o_scr_start
);

  // Register pointer, 5 bits like the real 6845
  logic [4:0] crtc_idx;

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      crtc_idx    <= '0;
      o_h_disp    <= '0;
      o_v_disp    <= '0;
      o_scr_start <= '0;
    end else begin
      if (bus.crtc_idx_wr) begin
        crtc_idx <= bus.wr_data[4:0];
      end
      // Data goes where the pointer says
      if (bus.crtc_data_wr) begin
        case (crtc_idx)
          CRTC_H_DISP: begin
            o_h_disp <= bus.wr_data;
          end
          CRTC_V_DISP: begin
            o_v_disp <= bus.wr_data;
          end
          CRTC_SCR_HI: begin
            // Only six bits on the high half
            o_scr_start[13:8] <= bus.wr_data[5:0];
          end
          CRTC_SCR_LO: begin
            o_scr_start[7:0] <= bus.wr_data;
          end
          default: begin
            // Timing registers not modelled
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cpc_gate_array.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_gate_array import cpc_pkg::*; (
  input  wire logic   clk_cpu,
  input  wire logic   pwr_up_reset_n,
  cpc_bus_if.target   bus,
  input  wire pen_t   i_pen_index,
  output logic [1:0]  o_mode,
  output colour_t     o_border_colour,
  output colour_t     o_pen_colour,
  output logic        o_hi_rom_dis,
  output logic        o_lo_rom_dis,
  output logic [2:0]  o_ram_bank,
  output logic [2:0]  o_ram_config
);

  // Written byte seen through the command views
  ga_word_u ga_word;
  ga_cmd_e  ga_cmd;

  // Pen pointer and border flag from the last select
  pen_t     pen;
  logic     border_sel;

  // Ink palette, one hardware colour per pen
  colour_t  palette [16];

  assign ga_word = bus.wr_data;
  assign ga_cmd  = ga_word.pen_sel.cmd;

  // ==========================================================================
  // Command registers
  // ==========================================================================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      pen             <= '0;
      border_sel      <= 1'b0;
      o_border_colour <= '0;
      o_mode          <= '0;
      o_hi_rom_dis    <= 1'b0;
      o_lo_rom_dis    <= 1'b0;
      o_ram_bank      <= '0;
      o_ram_config    <= '0;
    end else if (bus.ga_wr) begin
      case (ga_cmd)
        SELECT_PEN: begin
          border_sel <= ga_word.pen_sel.border;
          pen        <= ga_word.pen_sel.pen;
        end
        SET_COLOUR: begin
          // Palette side handled below
          if (border_sel) begin
            o_border_colour <= ga_word.colour.colour;
          end
        end
        ROM_MODE: begin
          o_hi_rom_dis <= ga_word.rom_mode.hi_rom_dis;
          o_lo_rom_dis <= ga_word.rom_mode.lo_rom_dis;
          o_mode       <= ga_word.rom_mode.mode;
        end
        RAM_CFG: begin
          o_ram_bank   <= ga_word.ram.bank;
          o_ram_config <= ga_word.ram.cfg;
        end
      endcase
    end
  end

  // Palette write when the pen is not the border
  always_ff @(posedge clk_cpu) begin
    if (bus.ga_wr && (ga_cmd == SET_COLOUR) && !border_sel) begin
      palette[pen] <= ga_word.colour.colour;
    end
  end

  // Video side lookup, straight from the pen pins
  assign o_pen_colour = palette[i_pen_index];

endmodule

`default_nettype wire

/* logic/cpc_io_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_io_decode import cpc_pkg::*; (
  input  wire addr_t  i_address,
  input  wire byte_t  i_data,
  input  wire logic   i_n_rd,
  input  wire logic   i_n_wr,
  input  wire logic   i_n_mreq,
  input  wire logic   i_n_iorq,
  cpc_bus_if.decoder  bus
);

  // Active high cycle types
  logic  io_wr;
  logic  io_rd;

  // Raw selects before priority
  logic  ga_cs;
  logic  rom_bank_cs;
  byte_t port_hi;

  assign io_wr = !i_n_wr && !i_n_iorq;
  assign io_rd = !i_n_rd && !i_n_iorq;

  // Memory cycles
  assign bus.mem_wr = !i_n_wr && !i_n_mreq;
  assign bus.mem_rd = !i_n_rd && !i_n_mreq;

  // Gate array answers to A15 low, A14 high
  assign ga_cs       = !i_address[15] && i_address[14];
  // Upper ROM select only looks at A13
  assign rom_bank_cs = !i_address[13];
  assign port_hi     = i_address[15:8];

  assign bus.wr_data = i_data;
  assign bus.region  = i_address[15:14];

  // PPI reads, full high byte compare
  assign bus.ppi_a_rd = io_rd && (port_hi == PORT_PPI_A);
  assign bus.ppi_b_rd = io_rd && (port_hi == PORT_PPI_B);

  // ==========================================================================
  // Write target priority
  // ==========================================================================
  always_comb begin
    bus.ga_wr        = 1'b0;
    bus.rom_bank_wr  = 1'b0;
    bus.ppi_a_wr     = 1'b0;
    bus.ppi_c_wr     = 1'b0;
    bus.ppi_ctrl_wr  = 1'b0;
    bus.crtc_idx_wr  = 1'b0;
    bus.crtc_data_wr = 1'b0;
    if (io_wr) begin
      // Loose gate array and ROM decodes win over full compares
      if (ga_cs) begin
        bus.ga_wr = 1'b1;
      end else if (rom_bank_cs) begin
        bus.rom_bank_wr = 1'b1;
      end else if (port_hi == PORT_PPI_A) begin
        bus.ppi_a_wr = 1'b1;
      end else if (port_hi == PORT_PPI_C) begin
        bus.ppi_c_wr = 1'b1;
      end else if (port_hi == PORT_PPI_CTRL) begin
        bus.ppi_ctrl_wr = 1'b1;
      end else if (port_hi == PORT_CRTC_IDX) begin
        bus.crtc_idx_wr = 1'b1;
      end else if (port_hi == PORT_CRTC_DATA) begin
        bus.crtc_data_wr = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/cpc_mem_map.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_mem_map import cpc_pkg::*; #(
  parameter byte_t ROM_HI_BANK = 8'd7
) (
  input  wire logic   clk_cpu,
  input  wire logic   pwr_up_reset_n,
  cpc_bus_if.target   bus,
  input  wire addr_t  i_address,
  input  wire logic   i_hi_rom_dis,
  input  wire logic   i_lo_rom_dis,
  input  wire byte_t  i_ram_data,
  input  wire byte_t  i_vram_data,
  input  wire byte_t  i_rom_data,
  input  wire byte_t  i_io_rd_data,
  input  wire logic   i_io_rd_valid,
  output byte_t       o_data,
  output addr_t       o_rom_addr,
  output logic        o_ram_we,
  output logic        o_vram_we
);

  // Upper ROM select
  byte_t      rom_bank;
  // 16K image used for the upper ROM
  logic [1:0] rom_img;

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      rom_bank <= '0;
    end else if (bus.rom_bank_wr) begin
      rom_bank <= bus.wr_data;
    end
  end

  // ==========================================================================
  // ROM addressing
  // ==========================================================================
  // Image 0 is the OS, image 1 BASIC, image 2 the extra upper ROM
  assign rom_img    = (rom_bank == ROM_HI_BANK) ? 2'b10 : 2'b01;
  assign o_rom_addr = (bus.region == 2'd0) ? i_address : {rom_img, i_address[13:0]};

  // Top 16K is the screen
  assign o_ram_we  = bus.mem_wr && (bus.region != 2'd3);
  assign o_vram_we = bus.mem_wr && (bus.region == 2'd3);

  // ==========================================================================
  // CPU read data
  // ==========================================================================
  always_comb begin
    o_data = '0;
    if (bus.mem_rd) begin
      case (bus.region)
        2'd0: begin
          o_data = i_lo_rom_dis ? i_ram_data : i_rom_data;
        end
        2'd3: begin
          // Screen RAM shows through when upper ROM is off
          o_data = i_hi_rom_dis ? i_vram_data : i_rom_data;
        end
        default: begin
          o_data = i_ram_data;
        end
      endcase
    end else if (i_io_rd_valid) begin
      o_data = i_io_rd_data;
    end
  end

endmodule

`default_nettype wire

/* logic/cpc_pkg.sv */
`default_nettype none

package cpc_pkg;

  // Bus and field widths
  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [4:0]  colour_t;
  typedef logic [3:0]  pen_t;
  typedef logic [13:0] scr_start_t;

  // PPI ports, matched on the high address byte
  localparam byte_t PORT_PPI_A     = 8'hF4;
  localparam byte_t PORT_PPI_B     = 8'hF5;
  localparam byte_t PORT_PPI_C     = 8'hF6;
  localparam byte_t PORT_PPI_CTRL  = 8'hF7;

  // CRTC index and data ports
  localparam byte_t PORT_CRTC_IDX  = 8'hBC;
  localparam byte_t PORT_CRTC_DATA = 8'hBD;

  // CRTC registers the core keeps
  localparam logic [4:0] CRTC_H_DISP = 5'd1;
  localparam logic [4:0] CRTC_V_DISP = 5'd6;
  localparam logic [4:0] CRTC_SCR_HI = 5'd12;
  localparam logic [4:0] CRTC_SCR_LO = 5'd13;

  // Port B read pattern, bit 0 replaced by vsync
  localparam byte_t PPI_B_ID = 8'h1E;

  // ==========================================================================
  // Gate array command byte
  // ==========================================================================
  // Function code, always in bits 7..6
  typedef enum logic [1:0] {
    SELECT_PEN = 2'd0,
    SET_COLOUR = 2'd1,
    ROM_MODE   = 2'd2,
    RAM_CFG    = 2'd3
  } ga_cmd_e;

  typedef struct packed {
    ga_cmd_e    cmd;
    logic       rsvd;
    logic       border;
    pen_t       pen;
  } ga_pen_sel_t;

  typedef struct packed {
    ga_cmd_e    cmd;
    logic       rsvd;
    colour_t    colour;
  } ga_colour_t;

  typedef struct packed {
    ga_cmd_e    cmd;
    logic [1:0] rsvd;
    logic       hi_rom_dis;
    logic       lo_rom_dis;
    logic [1:0] mode;
  } ga_rom_mode_t;

  typedef struct packed {
    ga_cmd_e    cmd;
    logic [2:0] bank;
    logic [2:0] cfg;
  } ga_ram_t;

  // One written byte, four views
  typedef union packed {
    ga_pen_sel_t  pen_sel;
    ga_colour_t   colour;
    ga_rom_mode_t rom_mode;
    ga_ram_t      ram;
  } ga_word_u;

endpackage

`default_nettype wire

/* logic/cpc_ppi_port.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_ppi_port import cpc_pkg::*; (
  input  wire logic   clk_cpu,
  input  wire logic   pwr_up_reset_n,
  cpc_bus_if.target   bus,
  input  wire byte_t  i_kbd_data,
  input  wire logic   i_long_vsync,
  output byte_t       o_psg_data,
  output logic [3:0]  o_kbd_row,
  output logic        o_psg_bdir,
  output logic        o_psg_bc1,
  output byte_t       o_ppi_control,
  output byte_t       o_rd_data,
  output logic        o_rd_valid
);

  // Port C drives keyboard row and PSG control
  byte_t ppi_c;

  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_psg_data    <= '0;
      ppi_c         <= '0;
      o_ppi_control <= '0;
    end else begin
      if (bus.ppi_a_wr) begin
        o_psg_data <= bus.wr_data;
      end
      if (bus.ppi_c_wr) begin
        ppi_c <= bus.wr_data;
      end
      if (bus.ppi_ctrl_wr) begin
        o_ppi_control <= bus.wr_data;
      end
    end
  end

  assign o_kbd_row  = ppi_c[3:0];
  assign o_psg_bdir = ppi_c[7];
  assign o_psg_bc1  = ppi_c[6];

  // Read value, port A first
  assign o_rd_valid = bus.ppi_a_rd || bus.ppi_b_rd;
  assign o_rd_data  = bus.ppi_a_rd ? i_kbd_data :
                      bus.ppi_b_rd ? {PPI_B_ID[7:1], i_long_vsync} : '0;

endmodule

`default_nettype wire

/* tests/cpc_bus_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module cpc_bus_assert import cpc_pkg::*; (
  input  wire logic   clk_cpu,
  input  wire logic   pwr_up_reset_n,
  input  wire logic   i_n_rd,
  input  wire logic   i_n_wr,
  input  wire logic   i_n_mreq,
  input  wire logic   i_n_iorq,
  input  wire byte_t  o_data,
  input  wire logic   o_ram_we,
  input  wire logic   o_vram_we,
  input  wire logic   o_psg_bdir
);

  // Memory or I/O read in progress
  logic cpu_rd;
  // Memory write cycle on the pins
  logic cpu_mem_wr;

  assign cpu_rd     = (!i_n_rd && !i_n_mreq) || (!i_n_rd && !i_n_iorq);
  assign cpu_mem_wr = !i_n_wr && !i_n_mreq;

  // A write enable only in a memory write, and never both at once
  we_one_target: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    ((o_ram_we || o_vram_we) == cpu_mem_wr) && !(o_ram_we && o_vram_we))
    else $error("RAM write enables do not match the memory write cycle");

  // Read data parks at zero between reads
  data_idle_zero: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    !cpu_rd |-> (o_data == 8'h00))
    else $error("CPU read data not zero while no read is active");

  // PSG bus direction cleared by reset
  bdir_after_reset: assert property (@(posedge clk_cpu)
    !pwr_up_reset_n |=> !o_psg_bdir)
    else $error("PSG bdir still high in the cycle after reset");

endmodule

bind cpc_bus_top cpc_bus_assert i_assert (
  .clk_cpu, .pwr_up_reset_n, .i_n_rd, .i_n_wr, .i_n_mreq, .i_n_iorq,
  .o_data, .o_ram_we, .o_vram_we, .o_psg_bdir
);

`default_nettype wire

/* tests/tb_cpc_bus_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpc_bus_top import cpc_pkg::*; ();

  localparam int HALF_PERIOD = 4;

  // Z80 bus cycle kinds
  typedef enum logic [1:0] {IO_WR, IO_RD, MEM_WR, MEM_RD} op_e;

  // DUT output checked by a row
  typedef enum logic [4:0] {
    OBS_DATA, OBS_ROM_ADDR, OBS_RAM_WE, OBS_VRAM_WE, OBS_MODE, OBS_BORDER,
    OBS_PEN_COLOUR, OBS_RAM_BANK, OBS_RAM_CONFIG, OBS_H_DISP, OBS_V_DISP,
    OBS_SCR_START, OBS_KBD_ROW, OBS_PSG_BDIR, OBS_PSG_BC1, OBS_PSG_DATA, OBS_PPI_CTRL
  } obs_e;

  // Fixed value, or one of the random input bytes
  typedef enum logic [2:0] {SRC_FIX, SRC_RAM, SRC_VRAM, SRC_ROM, SRC_KBD} src_e;

  typedef struct packed {
    op_e         op;
    addr_t       addr;
    byte_t       data;
    // Pen index in bits 3..0, vsync level in bit 4
    byte_t       aux;
    obs_e        obs;
    src_e        src;
    logic [15:0] expected;
  } row_t;

  row_t rows[$];
  logic table_ready = 1'b0;
  int   checks_done = 0;

  // DUT inputs
  logic  clk_cpu = 1'b0;
  logic  pwr_up_reset_n;
  addr_t i_address;
  byte_t i_data;
  logic  i_n_rd, i_n_wr, i_n_mreq, i_n_iorq;
  byte_t i_ram_data, i_vram_data, i_rom_data, i_kbd_data;
  logic  i_long_vsync;
  pen_t  i_pen_index;

  // DUT outputs
  wire byte_t      o_data;
  wire addr_t      o_rom_addr;
  wire logic       o_ram_we, o_vram_we;
  wire logic [1:0] o_mode;
  wire colour_t    o_border_colour, o_pen_colour;
  wire logic [2:0] o_ram_bank, o_ram_config;
  wire byte_t      o_h_disp, o_v_disp;
  wire scr_start_t o_scr_start;
  wire logic [3:0] o_kbd_row;
  wire logic       o_psg_bdir, o_psg_bc1;
  wire byte_t      o_psg_data, o_ppi_control;

  cpc_bus_top #(.ROM_HI_BANK (8'd7)) i_dut (.*);

  always #HALF_PERIOD clk_cpu = ~clk_cpu;

  // ==========================================================================
  // Gate array command bytes
  // ==========================================================================
  function automatic byte_t pen_select(input logic border, input pen_t pen);
    ga_word_u w;
    w.pen_sel = ga_pen_sel_t'{SELECT_PEN, 1'b0, border, pen};
    return w;
  endfunction

  function automatic byte_t set_colour(input colour_t colour);
    ga_word_u w;
    w.colour = ga_colour_t'{SET_COLOUR, 1'b0, colour};
    return w;
  endfunction

  function automatic byte_t rom_mode(input logic hi_dis, input logic lo_dis,
                                     input logic [1:0] mode);
    ga_word_u w;
    w.rom_mode = ga_rom_mode_t'{ROM_MODE, 2'b00, hi_dis, lo_dis, mode};
    return w;
  endfunction

  function automatic byte_t ram_cfg(input logic [2:0] bank, input logic [2:0] cfg);
    ga_word_u w;
    w.ram = ga_ram_t'{RAM_CFG, bank, cfg};
    return w;
  endfunction

  // ==========================================================================
  // Observation and checking
  // ==========================================================================
  function automatic logic [15:0] observe(input obs_e sel);
    case (sel)
      OBS_DATA:       return o_data;
      OBS_ROM_ADDR:   return o_rom_addr;
      OBS_RAM_WE:     return o_ram_we;
      OBS_VRAM_WE:    return o_vram_we;
      OBS_MODE:       return o_mode;
      OBS_BORDER:     return o_border_colour;
      OBS_PEN_COLOUR: return o_pen_colour;
      OBS_RAM_BANK:   return o_ram_bank;
      OBS_RAM_CONFIG: return o_ram_config;
      OBS_H_DISP:     return o_h_disp;
      OBS_V_DISP:     return o_v_disp;
      OBS_SCR_START:  return o_scr_start;
      OBS_KBD_ROW:    return o_kbd_row;
      OBS_PSG_BDIR:   return o_psg_bdir;
      OBS_PSG_BC1:    return o_psg_bc1;
      OBS_PSG_DATA:   return o_psg_data;
      default:        return o_ppi_control;
    endcase
  endfunction

  // DUT port name for error lines
  function automatic string port_name(input obs_e sel);
    case (sel)
      OBS_DATA:       return "o_data";
      OBS_ROM_ADDR:   return "o_rom_addr";
      OBS_RAM_WE:     return "o_ram_we";
      OBS_VRAM_WE:    return "o_vram_we";
      OBS_MODE:       return "o_mode";
      OBS_BORDER:     return "o_border_colour";
      OBS_PEN_COLOUR: return "o_pen_colour";
      OBS_RAM_BANK:   return "o_ram_bank";
      OBS_RAM_CONFIG: return "o_ram_config";
      OBS_H_DISP:     return "o_h_disp";
      OBS_V_DISP:     return "o_v_disp";
      OBS_SCR_START:  return "o_scr_start";
      OBS_KBD_ROW:    return "o_kbd_row";
      OBS_PSG_BDIR:   return "o_psg_bdir";
      OBS_PSG_BC1:    return "o_psg_bc1";
      OBS_PSG_DATA:   return "o_psg_data";
      default:        return "o_ppi_control";
    endcase
  endfunction

  // Random sources resolve to the byte currently driven
  function automatic logic [15:0] expected_of(input row_t r);
    case (r.src)
      SRC_RAM:  return i_ram_data;
      SRC_VRAM: return i_vram_data;
      SRC_ROM:  return i_rom_data;
      SRC_KBD:  return i_kbd_data;
      default:  return r.expected;
    endcase
  endfunction

  task automatic stop_on_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input obs_e sel, input logic [15:0] exp_val);
    logic [15:0] got;
    got = observe(sel);
    assert (got === exp_val) else begin
      $display("Mismatch %s: got 0x%h, expected 0x%h", port_name(sel), got, exp_val);
      stop_on_failure();
    end
    checks_done++;
  endtask

  // ==========================================================================
  // Bus driving
  // ==========================================================================
  // Address and data stay put, only the strobes drop
  task automatic drive_idle();
    i_n_rd   = 1'b1;
    i_n_wr   = 1'b1;
    i_n_mreq = 1'b1;
    i_n_iorq = 1'b1;
  endtask

  // Three memory bytes kept distinct so a wrong mux leg shows
  task automatic refresh_inputs();
    i_ram_data  = 8'($urandom);
    i_vram_data = i_ram_data ^ 8'hA5;
    i_rom_data  = i_ram_data ^ 8'h3C;
    i_kbd_data  = 8'($urandom);
  endtask

  task automatic apply_row(input row_t r);
    @(posedge clk_cpu);
    #1;
    refresh_inputs();
    i_address    = r.addr;
    i_data       = r.data;
    i_pen_index  = r.aux[3:0];
    i_long_vsync = r.aux[4];
    i_n_rd       = !(r.op == IO_RD || r.op == MEM_RD);
    i_n_wr       = !(r.op == IO_WR || r.op == MEM_WR);
    i_n_iorq     = !(r.op == IO_RD || r.op == IO_WR);
    i_n_mreq     = !(r.op == MEM_RD || r.op == MEM_WR);
    case (r.op)
      IO_WR: begin
        // Written on this edge, visible during the idle cycle
        @(posedge clk_cpu);
        #1;
        drive_idle();
        @(negedge clk_cpu);
        check_value(r.obs, expected_of(r));
      end
      MEM_WR: begin
        // Write enables are combinational, checked mid-cycle
        @(negedge clk_cpu);
        check_value(r.obs, expected_of(r));
        @(posedge clk_cpu);
        #1;
        drive_idle();
      end
      default: begin
        @(negedge clk_cpu);
        check_value(r.obs, expected_of(r));
      end
    endcase
  endtask

  task automatic add_row(input op_e op, input addr_t addr, input byte_t data,
                         input byte_t aux, input obs_e obs, input src_e src,
                         input logic [15:0] expected);
    rows.push_back(row_t'{op, addr, data, aux, obs, src, expected});
  endtask

  // ==========================================================================
  // Stimulus table
  // ==========================================================================
  task automatic build_table();
    // Reset state
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_MODE, SRC_FIX, 16'h0000);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_RAM_BANK, SRC_FIX, 16'h0000);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_SCR_START, SRC_FIX, 16'h0000);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_PSG_BDIR, SRC_FIX, 16'h0000);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_DATA, SRC_ROM, 16'h0000);
    add_row(MEM_RD, 16'hC123, 8'h00, 8'h00, OBS_DATA, SRC_ROM, 16'h0000);
    add_row(MEM_RD, 16'hC123, 8'h00, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h4123);
    add_row(MEM_RD, 16'h1234, 8'h00, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h1234);
    add_row(MEM_RD, 16'h4000, 8'h00, 8'h00, OBS_DATA, SRC_RAM, 16'h0000);
    // Palette, border, mode and RAM config
    add_row(IO_WR, 16'h7F00, pen_select(1'b0, 4'd5), 8'h05, OBS_BORDER, SRC_FIX, 16'h00);
    add_row(IO_WR, 16'h7F00, set_colour(5'h14), 8'h05, OBS_PEN_COLOUR, SRC_FIX, 16'h14);
    add_row(IO_WR, 16'h7F00, pen_select(1'b1, 4'd0), 8'h05, OBS_BORDER, SRC_FIX, 16'h00);
    add_row(IO_WR, 16'h7F00, set_colour(5'h0B), 8'h05, OBS_BORDER, SRC_FIX, 16'h0B);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h05, OBS_PEN_COLOUR, SRC_FIX, 16'h0014);
    add_row(IO_WR, 16'h7F00, rom_mode(1'b0, 1'b1, 2'd2), 8'h00, OBS_MODE, SRC_FIX, 16'h2);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_DATA, SRC_RAM, 16'h0000);
    add_row(MEM_RD, 16'hC000, 8'h00, 8'h00, OBS_DATA, SRC_ROM, 16'h0000);
    add_row(IO_WR, 16'h7F00, rom_mode(1'b1, 1'b0, 2'd1), 8'h00, OBS_MODE, SRC_FIX, 16'h1);
    add_row(MEM_RD, 16'h0000, 8'h00, 8'h00, OBS_DATA, SRC_ROM, 16'h0000);
    add_row(MEM_RD, 16'hC000, 8'h00, 8'h00, OBS_DATA, SRC_VRAM, 16'h0000);
    add_row(IO_WR, 16'h7F00, ram_cfg(3'd5, 3'd2), 8'h00, OBS_RAM_BANK, SRC_FIX, 16'h5);
    add_row(MEM_RD, 16'h8000, 8'h00, 8'h00, OBS_RAM_CONFIG, SRC_FIX, 16'h0002);
    // CRTC, index 2 is not kept
    add_row(IO_WR, 16'hBC00, 8'h01, 8'h00, OBS_H_DISP, SRC_FIX, 16'h0000);
    add_row(IO_WR, 16'hBD00, 8'h28, 8'h00, OBS_H_DISP, SRC_FIX, 16'h0028);
    add_row(IO_WR, 16'hBC00, 8'h0C, 8'h00, OBS_SCR_START, SRC_FIX, 16'h0000);
    add_row(IO_WR, 16'hBD00, 8'h3F, 8'h00, OBS_SCR_START, SRC_FIX, 16'h3F00);
    add_row(IO_WR, 16'hBC00, 8'h0D, 8'h00, OBS_SCR_START, SRC_FIX, 16'h3F00);
    add_row(IO_WR, 16'hBD00, 8'h80, 8'h00, OBS_SCR_START, SRC_FIX, 16'h3F80);
    add_row(IO_WR, 16'hBC00, 8'h06, 8'h00, OBS_V_DISP, SRC_FIX, 16'h0000);
    add_row(IO_WR, 16'hBD00, 8'h19, 8'h00, OBS_V_DISP, SRC_FIX, 16'h0019);
    add_row(IO_WR, 16'hBC00, 8'h02, 8'h00, OBS_H_DISP, SRC_FIX, 16'h0028);
    add_row(IO_WR, 16'hBD00, 8'h55, 8'h00, OBS_SCR_START, SRC_FIX, 16'h3F80);
    add_row(MEM_RD, 16'h8000, 8'h00, 8'h00, OBS_H_DISP, SRC_FIX, 16'h0028);
    add_row(MEM_RD, 16'h8000, 8'h00, 8'h00, OBS_V_DISP, SRC_FIX, 16'h0019);
    // PPI ports
    add_row(IO_WR, 16'hF600, 8'hC3, 8'h00, OBS_KBD_ROW, SRC_FIX, 16'h0003);
    add_row(MEM_RD, 16'h8000, 8'h00, 8'h00, OBS_PSG_BDIR, SRC_FIX, 16'h0001);
    add_row(MEM_RD, 16'h8000, 8'h00, 8'h00, OBS_PSG_BC1, SRC_FIX, 16'h0001);
    add_row(IO_WR, 16'hF400, 8'h77, 8'h00, OBS_PSG_DATA, SRC_FIX, 16'h0077);
    add_row(IO_WR, 16'hF700, 8'h82, 8'h00, OBS_PPI_CTRL, SRC_FIX, 16'h0082);
    add_row(IO_RD, 16'hF400, 8'h00, 8'h00, OBS_DATA, SRC_KBD, 16'h0000);
    add_row(IO_RD, 16'hF500, 8'h00, 8'h00, OBS_DATA, SRC_FIX, 16'h001E);
    add_row(IO_RD, 16'hF500, 8'h00, 8'h10, OBS_DATA, SRC_FIX, 16'h001F);
    add_row(IO_RD, 16'hBC00, 8'h00, 8'h00, OBS_DATA, SRC_FIX, 16'h0000);
    // Upper ROM bank, idle address DF00 sits in region 3
    add_row(IO_WR, 16'hDF00, 8'h07, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h9F00);
    add_row(MEM_RD, 16'hC123, 8'h00, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h8123);
    add_row(IO_WR, 16'hDF00, 8'h03, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h5F00);
    add_row(MEM_RD, 16'hC123, 8'h00, 8'h00, OBS_ROM_ADDR, SRC_FIX, 16'h4123);
    // Memory write enables
    add_row(MEM_WR, 16'h4000, 8'h5A, 8'h00, OBS_RAM_WE, SRC_FIX, 16'h0001);
    add_row(MEM_WR, 16'h4000, 8'h5A, 8'h00, OBS_VRAM_WE, SRC_FIX, 16'h0000);
    add_row(MEM_WR, 16'hC000, 8'hA5, 8'h00, OBS_VRAM_WE, SRC_FIX, 16'h0001);
    add_row(MEM_WR, 16'hC000, 8'hA5, 8'h00, OBS_RAM_WE, SRC_FIX, 16'h0000);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'hB8D04899));
    pwr_up_reset_n = 1'b0;
    i_address      = '0;
    i_data         = '0;
    i_ram_data     = '0;
    i_vram_data    = '0;
    i_rom_data     = '0;
    i_kbd_data     = '0;
    i_long_vsync   = 1'b0;
    i_pen_index    = '0;
    drive_idle();
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk_cpu);
    #1;
    pwr_up_reset_n = 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    @(posedge clk_cpu);
    #1;
    drive_idle();
    if (checks_done == rows.size()) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("Not every table row was checked");
      stop_on_failure();
    end
  end

  // Watchdog, four cycles per row plus reset margin
  initial begin
    wait (table_ready);
    repeat (rows.size() * 4 + 20) @(posedge clk_cpu);
    $display("Timeout: the stimulus table did not finish in time");
    stop_on_failure();
  end

endmodule

`default_nettype wire
